// ==== design/game_pkg.sv ====
package game_pkg;

	localparam int GRID = 8;

	typedef logic [2:0] col_t;	// column or row index
	typedef logic [7:0] row_bits_t;	// bit c is column c, 0 lights it
	typedef logic [7:0] lives_t;

	localparam col_t BOTTOM_ROW = 3'd7;	// player row
	localparam col_t SHOT_START = 3'd6;	// new shots appear here
	localparam lives_t LIVES_INIT = 8'd5;

	// tick periods in CLK cycles on the board
	localparam int STEP_DIV_DEF = 4000000;
	localparam int FALL_DIV_DEF = 12500000;

	// column c spawns when acc % SPAWN_MOD[c] == SPAWN_REM[c]
	localparam logic [7:0] SPAWN_MOD [GRID] = '{
		8'd9,
		8'd31,
		8'd23,
		8'd13,
		8'd8,
		8'd11,
		8'd19,
		8'd8
	};
	localparam logic [7:0] SPAWN_REM [GRID] = '{
		8'd2,
		8'd13,
		8'd3,
		8'd5,
		8'd1,
		8'd2,
		8'd7,
		8'd4
	};

	localparam logic [7:0] RND_SEED = 8'd20;
	localparam logic [7:0] RND_STEP_SEED = 8'd44;

	// game over cross, indexed by row
	localparam row_bits_t GG_GLYPH [GRID] = '{
		8'b01111110,
		8'b10111101,
		8'b11011011,
		8'b11100111,
		8'b11100111,
		8'b11011011,
		8'b10111101,
		8'b01111110
	};

	typedef enum logic [1:0] {
		CMD_NONE,
		CMD_LEFT,
		CMD_RIGHT,
		CMD_FIRE
	} cmd_t;

	typedef enum logic {
		GS_PLAY,
		GS_OVER
	} game_state_t;

endpackage

// ==== design/field_if.sv ====
`timescale 1ns/10ps

interface field_if;
	import game_pkg::*;

	col_t player;
	logic [GRID-1:0] item_active;
	col_t [GRID-1:0] item_row;	// one row index per column
	logic [GRID-1:0] shot_active;
	col_t [GRID-1:0] shot_row;
	game_state_t state;

	modport exec (
		output player, item_active, item_row,
		output shot_active, shot_row, state
	);

	modport render (
		input player, item_active, item_row,
		input shot_active, shot_row, state
	);

endinterface

// ==== design/tick_gen.sv ====
`timescale 1ns/10ps

module tick_gen #(
	parameter int STEP_DIV = game_pkg::STEP_DIV_DEF,
	parameter int FALL_DIV = game_pkg::FALL_DIV_DEF
) (
	input  logic CLK,
	input  logic reset,
	output logic step_tick,
	output logic fall_tick
);
	localparam int MAX_DIV = (STEP_DIV > FALL_DIV) ? STEP_DIV : FALL_DIV;
	localparam int CW = $clog2(MAX_DIV + 1);
	localparam int DIVS [2] = '{STEP_DIV, FALL_DIV};

	logic [CW-1:0] cnt [2];
	logic [1:0] ticks;	// 0 step, 1 fall

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			cnt[0] <= '0;
			cnt[1] <= '0;
			ticks <= '0;
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (cnt[i] == CW'(DIVS[i] - 1))
				begin
					cnt[i] <= '0;
					ticks[i] <= 1'b1;	// one cycle pulse on wrap
				end
				else
				begin
					cnt[i] <= cnt[i] + 1'b1;
					ticks[i] <= 1'b0;
				end
			end
		end
	end

	assign step_tick = ticks[0];
	assign fall_tick = ticks[1];

endmodule

// ==== design/input_decode.sv ====
`timescale 1ns/10ps

module input_decode (
	input  logic CLK,
	input  logic reset,
	input  logic step_tick,
	input  logic left,
	input  logic right,
	input  logic shoot,
	output game_pkg::cmd_t cmd,
	output logic cmd_valid
);
	import game_pkg::*;

	cmd_t next_cmd;

	// left wins over right, right over shoot
	always_comb
	begin
		if (left)
			next_cmd = CMD_LEFT;
		else if (right)
			next_cmd = CMD_RIGHT;
		else if (shoot)
			next_cmd = CMD_FIRE;
		else
			next_cmd = CMD_NONE;
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= step_tick;
	end

	always_ff @(posedge CLK)
	begin
		if (step_tick)
			cmd <= next_cmd;	// sampled once per step
	end

endmodule

// ==== design/field_execute.sv ====
`timescale 1ns/10ps

module field_execute (
	input  logic CLK,
	input  logic reset,
	input  logic fall_tick,
	input  game_pkg::cmd_t cmd,
	input  logic cmd_valid,
	output game_pkg::lives_t lives,
	field_if.exec field
);
	import game_pkg::*;

	col_t player;
	logic [GRID-1:0] item_active;
	col_t [GRID-1:0] item_row;
	logic [GRID-1:0] shot_active;
	col_t [GRID-1:0] shot_row;
	game_state_t state;
	lives_t lives_q;
	logic [7:0] rnd;	// spawn accumulator
	logic [7:0] rnd_step;

	col_t n_player;
	logic [GRID-1:0] n_item_active;
	col_t [GRID-1:0] n_item_row;
	logic [GRID-1:0] n_shot_active;
	col_t [GRID-1:0] n_shot_row;
	game_state_t n_state;
	lives_t n_lives;
	logic [7:0] n_rnd;
	logic [7:0] n_rnd_step;

	always_comb
	begin
		n_player = player;
		n_item_active = item_active;
		n_item_row = item_row;
		n_shot_active = shot_active;
		n_shot_row = shot_row;
		n_state = state;
		n_lives = lives_q;
		n_rnd = rnd;
		n_rnd_step = rnd_step;

		if (state == GS_PLAY)
		begin
			if (fall_tick)
			begin
				for (int c = 0; c < GRID; c++)
				begin
					if (shot_active[c])
					begin
						if (shot_row[c] == '0)
							n_shot_active[c] = 1'b0;	// left the top
						else
							n_shot_row[c] = shot_row[c] - 1'b1;
					end
					if (item_active[c])
					begin
						if (item_row[c] == BOTTOM_ROW)
						begin
							n_item_active[c] = 1'b0;
							if (col_t'(c) == player && n_lives != '0)
								n_lives = n_lives - 1'b1;	// missed item
						end
						else
							n_item_row[c] = item_row[c] + 1'b1;
					end
					if (n_item_active[c] && n_shot_active[c] &&
						{1'b0, n_shot_row[c]} <= {1'b0, n_item_row[c]} + 4'd1)
					begin
						n_item_active[c] = 1'b0;
						n_shot_active[c] = 1'b0;
					end
				end

				n_rnd = rnd + rnd_step;
				n_rnd_step = rnd_step + 1'b1;

				for (int c = 0; c < GRID; c++)
				begin
					if (!n_item_active[c] && (n_rnd % SPAWN_MOD[c]) == SPAWN_REM[c])
					begin
						n_item_active[c] = 1'b1;
						n_item_row[c] = '0;
					end
				end

				if (n_lives == '0)
					n_state = GS_OVER;
			end

			if (cmd_valid)
			begin
				case (cmd)
					CMD_LEFT:
						if (player != '0)
							n_player = player - 1'b1;
					CMD_RIGHT:
						if (player != col_t'(GRID - 1))
							n_player = player + 1'b1;
					CMD_FIRE:
						if (!n_shot_active[player])
						begin
							n_shot_active[player] = 1'b1;
							n_shot_row[player] = SHOT_START;
						end
					default:
						;
				endcase
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			player <= '0;
			item_active <= '0;
			shot_active <= '0;
			state <= GS_PLAY;
			lives_q <= LIVES_INIT;
			rnd <= RND_SEED;
			rnd_step <= RND_STEP_SEED;
		end
		else
		begin
			player <= n_player;
			item_active <= n_item_active;
			shot_active <= n_shot_active;
			state <= n_state;
			lives_q <= n_lives;
			rnd <= n_rnd;
			rnd_step <= n_rnd_step;
		end
	end

	always_ff @(posedge CLK)
	begin
		item_row <= n_item_row;
		shot_row <= n_shot_row;
	end

	assign field.player = player;
	assign field.item_active = item_active;
	assign field.item_row = item_row;
	assign field.shot_active = shot_active;
	assign field.shot_row = shot_row;
	assign field.state = state;
	assign lives = lives_q;

endmodule

// ==== design/matrix_render.sv ====
`timescale 1ns/10ps

module matrix_render (
	input  logic CLK,
	input  logic reset,
	field_if.render field,
	output game_pkg::col_t row_sel,
	output game_pkg::row_bits_t data_r,
	output game_pkg::row_bits_t data_g,
	output game_pkg::row_bits_t data_b
);
	import game_pkg::*;

	col_t nxt_row;
	row_bits_t nxt_r;
	row_bits_t nxt_g;
	row_bits_t nxt_b;

	assign nxt_row = row_sel + 1'b1;	// wraps after row 7

	always_comb
	begin
		nxt_r = '1;
		nxt_g = '1;
		nxt_b = '1;
		if (field.state == GS_OVER)
			nxt_r = GG_GLYPH[nxt_row];
		else
		begin
			for (int c = 0; c < GRID; c++)
			begin
				if (field.item_active[c] && field.item_row[c] == nxt_row)
					nxt_r[c] = 1'b0;
				if (field.shot_active[c] && field.shot_row[c] == nxt_row)
					nxt_g[c] = 1'b0;
				if (nxt_row == BOTTOM_ROW && field.player == col_t'(c))
					nxt_b[c] = 1'b0;	// player only on bottom row
			end
		end
	end

	// row select and data change on the same edge
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			row_sel <= '0;
			data_r <= '1;
			data_g <= '1;
			data_b <= '1;
		end
		else
		begin
			row_sel <= nxt_row;
			data_r <= nxt_r;
			data_g <= nxt_g;
			data_b <= nxt_b;
		end
	end

endmodule

// ==== design/drop_game_top.sv ====
`timescale 1ns/10ps

module drop_game_top #(
	parameter int STEP_DIV = game_pkg::STEP_DIV_DEF,
	parameter int FALL_DIV = game_pkg::FALL_DIV_DEF
) (
	input  logic CLK,
	input  logic reset,
	input  logic left,
	input  logic right,
	input  logic shoot,
	output game_pkg::col_t row_sel,
	output game_pkg::row_bits_t data_r,
	output game_pkg::row_bits_t data_g,
	output game_pkg::row_bits_t data_b,
	output game_pkg::lives_t lives
);
	import game_pkg::*;

	logic step_tick;
	logic fall_tick;
	cmd_t cmd;
	logic cmd_valid;

	field_if field ();

	tick_gen #(
		.STEP_DIV (STEP_DIV),
		.FALL_DIV (FALL_DIV)
	) u_tick (
		.CLK       (CLK),
		.reset     (reset),
		.step_tick (step_tick),
		.fall_tick (fall_tick)
	);

	input_decode u_decode (
		.CLK       (CLK),
		.reset     (reset),
		.step_tick (step_tick),
		.left      (left),
		.right     (right),
		.shoot     (shoot),
		.cmd       (cmd),
		.cmd_valid (cmd_valid)
	);

	field_execute u_exec (
		.CLK       (CLK),
		.reset     (reset),
		.fall_tick (fall_tick),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.lives     (lives),
		.field     (field)
	);

	matrix_render u_render (
		.CLK     (CLK),
		.reset   (reset),
		.field   (field),
		.row_sel (row_sel),
		.data_r  (data_r),
		.data_g  (data_g),
		.data_b  (data_b)
	);

endmodule

// ==== bench/tb_drop_game.sv ====
`timescale 1ns/10ps

module tb_drop_game;
	import game_pkg::*;

	localparam int STEP = 4;
	localparam int FALL = 16;
	localparam int TIMEOUT_CYCLES = 20000;	// 5 lives x 8 falls x 16, plus directed part and margin

	logic CLK = 1'b0;
	logic reset;
	logic left;
	logic right;
	logic shoot;
	col_t row_sel;
	row_bits_t data_r;
	row_bits_t data_g;
	row_bits_t data_b;
	lives_t lives;

	int cycle = 0;
	integer seed;
	logic [GRID-1:0] fired_cols;	// columns that got a fire command
	int player_model;
	lives_t lives_prev;
	int last_drop;

	row_bits_t cap_r [GRID];
	row_bits_t cap_g [GRID];
	row_bits_t cap_b [GRID];
	row_bits_t last_b [GRID];
	int rows_seen = 0;
	int cur_start;
	int frame_start;
	bit cur_play;
	bit cur_over;
	bit over_prev;
	bit frame_ready = 1'b0;

	drop_game_top #(
		.STEP_DIV (STEP),
		.FALL_DIV (FALL)
	) uut (
		.CLK     (CLK),
		.reset   (reset),
		.left    (left),
		.right   (right),
		.shoot   (shoot),
		.row_sel (row_sel),
		.data_r  (data_r),
		.data_g  (data_g),
		.data_b  (data_b),
		.lives   (lives)
	);

	always #10 CLK = ~CLK;

	task automatic fail_value(input string name, input int expected, input int actual);
		$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_text(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// lit where the column sits on either diagonal
	function automatic row_bits_t cross_row(input int r);
		row_bits_t v;
		v = '1;
		v[r] = 1'b0;
		v[GRID-1-r] = 1'b0;
		return v;
	endfunction

	task automatic check_frame();
		logic [GRID-1:0] green_seen;
		logic [GRID-1:0] lit;
		green_seen = '0;
		if (cur_play)
		begin
			for (int r = 0; r < GRID; r++)
			begin
				lit = ~cap_g[r];
				assert ((lit & green_seen) == '0)
					else fail_value("one_shot_per_column", 0, lit & green_seen);
				assert ((lit & ~fired_cols) == '0)
					else fail_value("shot_in_fired_column", 0, lit & ~fired_cols);
				green_seen = green_seen | lit;
				if (r == BOTTOM_ROW)
				begin
					assert (cap_g[r] == '1) else fail_value("no_shot_on_bottom", 8'hff, cap_g[r]);
					assert ($countones(~cap_b[r]) == 1)
						else fail_value("one_player_pixel", 1, $countones(~cap_b[r]));
				end
				else
					assert (cap_b[r] == '1) else fail_value("blue_dark_off_bottom", 8'hff, cap_b[r]);
			end
		end
		else if (cur_over)
		begin
			for (int r = 0; r < GRID; r++)
			begin
				assert (cap_r[r] == cross_row(r)) else fail_value("over_red", cross_row(r), cap_r[r]);
				assert (cap_g[r] == '1) else fail_value("over_green", 8'hff, cap_g[r]);
				assert (cap_b[r] == '1) else fail_value("over_blue", 8'hff, cap_b[r]);
			end
		end
	endtask

	// assemble frames from row 0 to row 7
	always @(negedge CLK)
	begin
		if (reset)
		begin
			rows_seen = 0;
			frame_ready = 1'b0;
			over_prev = 1'b0;
		end
		else
		begin
			if (row_sel == '0)
			begin
				rows_seen = 0;
				cur_start = cycle;
				cur_play = 1'b1;
				cur_over = 1'b1;
			end
			cap_r[row_sel] = data_r;
			cap_g[row_sel] = data_g;
			cap_b[row_sel] = data_b;
			if (over_prev)	// data lags lives by one cycle
				cur_play = 1'b0;
			else
				cur_over = 1'b0;
			rows_seen++;
			if (row_sel == BOTTOM_ROW && rows_seen == GRID)
			begin
				check_frame();
				last_b = cap_b;
				frame_start = cur_start;
				frame_ready = 1'b1;
			end
			over_prev = (lives == '0);
		end
	end

	always @(negedge CLK)
	begin
		if (reset)
		begin
			lives_prev = lives;
			last_drop = -FALL;
		end
		else
		begin
			assert (lives <= LIVES_INIT) else fail_value("lives_in_range", LIVES_INIT, lives);
			if (lives < lives_prev)
			begin
				assert (lives == lives_prev - 1'b1)
					else fail_value("lives_drop_by_one", lives_prev - 1, lives);
				assert (cycle - last_drop >= FALL)
					else fail_value("lives_drop_rate", FALL, cycle - last_drop);
				last_drop = cycle;
			end
			lives_prev = lives;
		end
	end

	lives_no_gain: assert property (@(posedge CLK) disable iff (reset) lives <= $past(lives))
		else fail_text("lives went up without a reset");

	always @(posedge CLK)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
			fail_text("timeout: the game did not reach its end within the cycle limit");
	end

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	// n cycles span exactly n / STEP step ticks
	task automatic hold_buttons(input logic l, input logic r, input logic s, input int n);
		left = l;
		right = r;
		shoot = s;
		repeat (n) next_cycle();
		left = 1'b0;
		right = 1'b0;
		shoot = 1'b0;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		left = 1'b0;
		right = 1'b0;
		shoot = 1'b0;
		fired_cols = '0;
		player_model = 0;
		repeat (8) next_cycle();
		reset = 1'b0;
	endtask

	task automatic wait_frame(input int min_start);
		@(posedge CLK);
		while (!(frame_ready && frame_start >= min_start))
			@(posedge CLK);
		#1;
	endtask

	task automatic move_player(input bit to_right, input int steps);
		for (int i = 0; i < steps; i++)
		begin
			if (to_right && player_model < GRID - 1)
				player_model++;
			else if (!to_right && player_model > 0)
				player_model--;
		end
		hold_buttons(!to_right, to_right, 1'b0, steps * STEP);
	endtask

	task automatic fire_shot();
		fired_cols[player_model] = 1'b1;
		hold_buttons(1'b0, 1'b0, 1'b1, STEP);
	endtask

	task automatic check_player(input string name, input int col);
		row_bits_t expected;
		wait_frame(cycle + 2);
		expected = ~(8'h01 << col);
		assert (last_b[BOTTOM_ROW] == expected) else fail_value(name, expected, last_b[BOTTOM_ROW]);
	endtask

	task automatic check_reset_frame(input string name);
		row_bits_t blue_exp;
		wait_frame(cycle);
		assert (lives == LIVES_INIT) else fail_value({name, "_lives"}, LIVES_INIT, lives);
		for (int r = 0; r < GRID; r++)
		begin
			blue_exp = (r == BOTTOM_ROW) ? 8'hfe : 8'hff;
			assert (cap_r[r] == '1) else fail_value({name, "_red"}, 8'hff, cap_r[r]);
			assert (cap_g[r] == '1) else fail_value({name, "_green"}, 8'hff, cap_g[r]);
			assert (cap_b[r] == blue_exp) else fail_value({name, "_blue"}, blue_exp, cap_b[r]);
		end
	endtask

	task automatic random_step();
		logic [31:0] pick;
		pick = $random(seed);
		case (pick[2:0])
			3'd0, 3'd1, 3'd2: move_player(1'b0, 1);
			3'd3, 3'd4, 3'd5: move_player(1'b1, 1);
			3'd6: fire_shot();
			default: hold_buttons(1'b0, 1'b0, 1'b0, STEP);
		endcase
	endtask

	initial
	begin
		seed = 32'hf3b0_2af9;
		reset = 1'b1;
		left = 1'b0;
		right = 1'b0;
		shoot = 1'b0;
		fired_cols = '0;
		player_model = 0;
		apply_reset();
		check_reset_frame("reset_state");
		move_player(1'b0, 2);
		check_player("left_at_column_0", 0);
		move_player(1'b1, 3);
		check_player("right_to_column_3", 3);
		move_player(1'b1, 7);
		check_player("right_stops_at_7", 7);
		fire_shot();
		wait_frame(cycle + 2);
		wait_frame(cycle + 2);
		while (lives != '0)
			random_step();
		repeat (3) wait_frame(cycle + 2);	// full game over frames
		apply_reset();
		check_reset_frame("reset_after_game_over");
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
design/game_pkg.sv
design/field_if.sv
design/tick_gen.sv
design/input_decode.sv
design/field_execute.sv
design/matrix_render.sv
design/drop_game_top.sv
bench/tb_drop_game.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_drop_game -f tb.f -o sim_drop_game \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_drop_game > sim.log 2>&1

grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed, see sim.log"; exit 1; }
